// ==== files.f ====
hdl/jtag_pkg.sv
hdl/dmi_pkg.sv
hdl/tck_edge_detect.sv
hdl/tap_controller.sv
hdl/ir_register.sv
hdl/dtm_data_registers.sv
hdl/dmi_request.sv
hdl/jtag_dtm_top.sv
test/tb_jtag_dtm.sv

// ==== Bender.yml ====
package:
  name: jtag_dtm

sources:
  - hdl/jtag_pkg.sv
  - hdl/dmi_pkg.sv
  - hdl/tck_edge_detect.sv
  - hdl/tap_controller.sv
  - hdl/ir_register.sv
  - hdl/dtm_data_registers.sv
  - hdl/dmi_request.sv
  - hdl/jtag_dtm_top.sv
  - target: test
    files:
      - test/tb_jtag_dtm.sv

// ==== test/tb_jtag_dtm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_jtag_dtm;

    localparam jtag_pkg::idcode_t IDCODE = 32'h10e31913;
    localparam int PHASE         = 8;
    localparam int PULSE_TIMEOUT = 200;

    logic               clk;
    logic               rst_n;
    logic               jtag_clk;
    logic               jtag_tms;
    logic               jtag_tdi;
    logic               jtag_tdo;
    logic               start_read;
    logic               start_write;
    dmi_pkg::dmi_addr_t dmi_addr;
    dmi_pkg::dmi_data_t dmi_wdata;

    int            errors = 0;
    int            tests = 0;
    int            read_count = 0;
    int            write_count = 0;
    logic [31:0]   rng;
    dmi_pkg::dmi_t last_dmi = '0;

    jtag_dtm_top #(
        .IDCODE      (IDCODE),
        .SYNC_STAGES (2)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .jtag_clk    (jtag_clk),
        .jtag_tms    (jtag_tms),
        .jtag_tdi    (jtag_tdi),
        .jtag_tdo    (jtag_tdo),
        .start_read  (start_read),
        .start_write (start_write),
        .dmi_addr    (dmi_addr),
        .dmi_wdata   (dmi_wdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // pulse counters, settled by the next falling edge
    always @(posedge clk)
    begin
        if (start_read)
        begin
            read_count <= read_count + 1;
        end
        if (start_write)
        begin
            write_count <= write_count + 1;
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_idcode(input string name, input jtag_pkg::idcode_t exp,
                                input jtag_pkg::idcode_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ir(input string name, input jtag_pkg::ir_t exp, input jtag_pkg::ir_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input dmi_pkg::dmi_addr_t exp,
                              input dmi_pkg::dmi_addr_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input dmi_pkg::dmi_data_t exp,
                              input dmi_pkg::dmi_data_t act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    // one jtag_clk period, tdo sampled just before the rising edge
    task automatic tck_pulse(input logic tms, input logic tdi, output logic tdo);
        jtag_clk = 1'b0;
        jtag_tms = tms;
        jtag_tdi = tdi;
        repeat (PHASE) @(negedge clk);
        tdo = jtag_tdo;
        jtag_clk = 1'b1;
        repeat (PHASE) @(negedge clk);
    endtask

    task automatic tms_move(input logic tms);
        logic unused;
        tck_pulse(tms, 1'b0, unused);
    endtask

    // from and back to RUN_TEST_IDLE
    task automatic scan_ir(input jtag_pkg::ir_t din, output jtag_pkg::ir_t dout);
        logic bit_out;
        tms_move(1'b1);
        tms_move(1'b1);
        tms_move(1'b0);
        tms_move(1'b0);
        for (int i = 0; i < jtag_pkg::IR_WIDTH; i++)
        begin
            tck_pulse(i == jtag_pkg::IR_WIDTH - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        tms_move(1'b1);
        tms_move(1'b0);
    endtask

    task automatic scan_dr(input int len, input dmi_pkg::dmi_t din, input bit via_pause,
                           output dmi_pkg::dmi_t dout);
        logic bit_out;
        dout = '0;
        tms_move(1'b1);
        tms_move(1'b0);
        tms_move(1'b0);
        for (int i = 0; i < len; i++)
        begin
            tck_pulse(i == len - 1, din[i], bit_out);
            dout[i] = bit_out;
        end
        // EXIT1 -> PAUSE -> PAUSE -> EXIT2
        if (via_pause)
        begin
            tms_move(1'b0);
            tms_move(1'b0);
            tms_move(1'b1);
        end
        tms_move(1'b1);
        tms_move(1'b0);
    endtask

    task automatic wait_pulse(input bit want_write, input int target, output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < PULSE_TIMEOUT)
        begin
            seen = want_write ? (write_count >= target) : (read_count >= target);
            if (!seen)
            begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        $display("%s: %s", name, (errors == errors_before) ? "ok" : "failed");
    endtask

    // one DMI scan, also checks that the previous value comes back out
    task automatic dmi_transfer(input string name, input dmi_pkg::dmi_op_t op, input bit via_pause);
        dmi_pkg::dmi_addr_t addr;
        dmi_pkg::dmi_data_t data;
        dmi_pkg::dmi_t      dout;
        int                 rd_before;
        int                 wr_before;
        bit                 exp_rd;
        bit                 exp_wr;
        bit                 seen;
        rng = next_rand(rng);
        addr = rng[9:0];
        rng = next_rand(rng);
        data = rng;
        exp_rd = (op == dmi_pkg::DMI_OP_READ);
        exp_wr = (op == dmi_pkg::DMI_OP_WRITE);
        rd_before = read_count;
        wr_before = write_count;
        scan_dr(dmi_pkg::DMI_WIDTH, {addr, data, op}, via_pause, dout);
        check_addr(name, last_dmi[43:34], dout[43:34]);
        check_data(name, last_dmi[33:2], dout[33:2]);
        check_bit(name, last_dmi[1], dout[1]);
        check_bit(name, last_dmi[0], dout[0]);
        if (exp_rd || exp_wr)
        begin
            wait_pulse(exp_wr, (exp_wr ? wr_before : rd_before) + 1, seen);
            if (!seen)
            begin
                $display("%s: no start pulse came within %0d cycles", name, PULSE_TIMEOUT);
                errors++;
            end
        end
        else
        begin
            repeat (PULSE_TIMEOUT) @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (read_count - rd_before != int'(exp_rd))
        begin
            $display("ERR %s start_read pulses expected %0d actual %0d", name, exp_rd,
                     read_count - rd_before);
            errors++;
        end
        if (write_count - wr_before != int'(exp_wr))
        begin
            $display("ERR %s start_write pulses expected %0d actual %0d", name, exp_wr,
                     write_count - wr_before);
            errors++;
        end
        check_addr(name, addr, dmi_addr);
        check_data(name, data, dmi_wdata);
        last_dmi = {addr, data, op};
    endtask

    task automatic idcode_after_reset();
        int            errors_before;
        dmi_pkg::dmi_t dout;
        errors_before = errors;
        scan_dr(32, '0, 1'b0, dout);
        check_idcode("idcode_after_reset", IDCODE, dout[31:0]);
        end_test("idcode_after_reset", errors_before);
    endtask

    task automatic ir_readback();
        int            errors_before;
        jtag_pkg::ir_t ir_out;
        dmi_pkg::dmi_t dout;
        errors_before = errors;
        scan_ir(jtag_pkg::IR_DMI, ir_out);
        check_ir("ir_readback", jtag_pkg::IR_IDCODE, ir_out);
        scan_ir(jtag_pkg::IR_DMI, ir_out);
        check_ir("ir_readback", jtag_pkg::IR_DMI, ir_out);
        // five edges with tms high land in TEST_LOGIC_RESET
        repeat (5) tms_move(1'b1);
        tms_move(1'b0);
        scan_dr(32, '0, 1'b0, dout);
        check_idcode("ir_readback", IDCODE, dout[31:0]);
        end_test("ir_readback", errors_before);
    endtask

    task automatic bypass_path(input string name, input jtag_pkg::ir_t code);
        int            errors_before;
        jtag_pkg::ir_t ir_out;
        dmi_pkg::dmi_t pattern;
        dmi_pkg::dmi_t dout;
        errors_before = errors;
        scan_ir(code, ir_out);
        rng = next_rand(rng);
        pattern = {28'h0, rng[15:0]};
        scan_dr(16, pattern, 1'b0, dout);
        check_bit(name, 1'b0, dout[0]);
        for (int i = 1; i < 16; i++)
        begin
            check_bit(name, pattern[i-1], dout[i]);
        end
        end_test(name, errors_before);
    endtask

    task automatic dmi_write();
        int            errors_before;
        jtag_pkg::ir_t ir_out;
        errors_before = errors;
        scan_ir(jtag_pkg::IR_DMI, ir_out);
        dmi_transfer("dmi_write", dmi_pkg::DMI_OP_WRITE, 1'b0);
        end_test("dmi_write", errors_before);
    endtask

    task automatic dmi_read_nop();
        int            errors_before;
        jtag_pkg::ir_t ir_out;
        errors_before = errors;
        scan_ir(jtag_pkg::IR_DMI, ir_out);
        dmi_transfer("dmi_read", dmi_pkg::DMI_OP_READ, 1'b0);
        dmi_transfer("dmi_nop", dmi_pkg::DMI_OP_NOP, 1'b0);
        dmi_transfer("dmi_reserved", dmi_pkg::DMI_OP_RESERVED, 1'b0);
        // this scan shifts out the reserved value
        dmi_transfer("dmi_readback", dmi_pkg::DMI_OP_NOP, 1'b0);
        end_test("dmi_read_nop", errors_before);
    endtask

    task automatic dmi_pause_write();
        int            errors_before;
        jtag_pkg::ir_t ir_out;
        errors_before = errors;
        scan_ir(jtag_pkg::IR_DMI, ir_out);
        dmi_transfer("dmi_pause_write", dmi_pkg::DMI_OP_WRITE, 1'b1);
        end_test("dmi_pause_write", errors_before);
    endtask

    initial
    begin
        rst_n = 1'b0;
        jtag_clk = 1'b0;
        jtag_tms = 1'b1;
        jtag_tdi = 1'b0;
        rng = 32'h912;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        tms_move(1'b0);
        idcode_after_reset();
        ir_readback();
        bypass_path("bypass_1f", jtag_pkg::IR_BYPASS);
        bypass_path("bypass_05", 5'h05);
        dmi_write();
        dmi_read_nop();
        dmi_pause_write();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
        begin
            $display("TEST RESULT: PASS");
        end
        else
        begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/jtag_dtm_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module jtag_dtm_top #(
    parameter jtag_pkg::idcode_t IDCODE      = 32'h12345678,
    parameter int                SYNC_STAGES = 2
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 jtag_clk,
    input  wire                 jtag_tms,
    input  wire                 jtag_tdi,
    output logic                jtag_tdo,
    output logic                start_read,
    output logic                start_write,
    output dmi_pkg::dmi_addr_t  dmi_addr,
    output dmi_pkg::dmi_data_t  dmi_wdata
);

    logic tck_rise;
    logic tck_fall;
    logic tms;
    logic tdi;

    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic capture_ir;
    logic shift_ir;
    logic update_ir;
    logic in_reset;

    jtag_pkg::ir_t ir;
    logic          ir_tdo;
    logic          dr_tdo;
    logic          dmi_update;
    dmi_pkg::dmi_t dmi_value;

    // pins into the clk domain
    tck_edge_detect #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_tck_edge_detect (
        .clk      (clk),
        .rst_n    (rst_n),
        .jtag_clk (jtag_clk),
        .jtag_tms (jtag_tms),
        .jtag_tdi (jtag_tdi),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tms      (tms),
        .tdi      (tdi)
    );

    tap_controller i_tap_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .tck_rise   (tck_rise),
        .tck_fall   (tck_fall),
        .tms        (tms),
        .ir_tdo     (ir_tdo),
        .dr_tdo     (dr_tdo),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .in_reset   (in_reset),
        .jtag_tdo   (jtag_tdo)
    );

    ir_register i_ir_register (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture_ir (capture_ir),
        .shift_ir   (shift_ir),
        .update_ir  (update_ir),
        .in_reset   (in_reset),
        .tdi        (tdi),
        .ir         (ir),
        .ir_tdo     (ir_tdo)
    );

    dtm_data_registers #(
        .IDCODE (IDCODE)
    ) i_dtm_data_registers (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture_dr (capture_dr),
        .shift_dr   (shift_dr),
        .update_dr  (update_dr),
        .tdi        (tdi),
        .ir         (ir),
        .dr_tdo     (dr_tdo),
        .dmi_update (dmi_update),
        .dmi_value  (dmi_value)
    );

    // DMI update to request pulses
    dmi_request i_dmi_request (
        .clk         (clk),
        .rst_n       (rst_n),
        .dmi_update  (dmi_update),
        .dmi_value   (dmi_value),
        .dmi_addr    (dmi_addr),
        .dmi_wdata   (dmi_wdata),
        .start_read  (start_read),
        .start_write (start_write)
    );

endmodule

`default_nettype wire

// ==== hdl/dmi_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module dmi_request (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 dmi_update,
    input  dmi_pkg::dmi_t       dmi_value,
    output dmi_pkg::dmi_addr_t  dmi_addr,
    output dmi_pkg::dmi_data_t  dmi_wdata,
    output logic                start_read,
    output logic                start_write
);

    dmi_pkg::dmi_op_t op;

    assign op = dmi_value[dmi_pkg::DMI_OP_LSB +: dmi_pkg::DMI_OP_BITS];

    // fields follow every update, whatever the op
    always_ff @(posedge clk)
    begin
        if (dmi_update)
        begin
            dmi_addr  <= dmi_value[dmi_pkg::DMI_ADDR_LSB +: dmi_pkg::DMI_ABITS];
            dmi_wdata <= dmi_value[dmi_pkg::DMI_DATA_LSB +: dmi_pkg::DMI_DATA_BITS];
        end
    end

    // one-cycle start pulses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            start_read  <= 1'b0;
            start_write <= 1'b0;
        end
        else
        begin
            start_read  <= 1'b0;
            start_write <= 1'b0;
            if (dmi_update)
            begin
                case (op)
                    dmi_pkg::DMI_OP_READ:  start_read <= 1'b1;
                    dmi_pkg::DMI_OP_WRITE: start_write <= 1'b1;
                    // nop and reserved only move the fields
                    dmi_pkg::DMI_OP_NOP, dmi_pkg::DMI_OP_RESERVED: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dtm_data_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module dtm_data_registers #(
    parameter jtag_pkg::idcode_t IDCODE = 32'h12345678
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            capture_dr,
    input  wire            shift_dr,
    input  wire            update_dr,
    input  wire            tdi,
    input  jtag_pkg::ir_t  ir,
    output logic           dr_tdo,
    output logic           dmi_update,
    output dmi_pkg::dmi_t  dmi_value
);

    jtag_pkg::idcode_t idcode_shift;
    logic              bypass_reg;
    dmi_pkg::dmi_t     dmi_shift;
    logic              sel_idcode;
    logic              sel_dmi;

    // anything that is not IDCODE or DMI goes through bypass
    always_comb
    begin
        sel_idcode = 1'b0;
        sel_dmi    = 1'b0;
        case (ir)
            jtag_pkg::IR_IDCODE: sel_idcode = 1'b1;
            jtag_pkg::IR_DMI:    sel_dmi = 1'b1;
            default:             ;
        endcase
    end

    // scan chains, only the selected one moves
    always_ff @(posedge clk)
    begin
        if (capture_dr)
        begin
            if (sel_idcode)
            begin
                idcode_shift <= IDCODE;
            end
            else if (sel_dmi)
            begin
                dmi_shift <= dmi_value;
            end
            else
            begin
                bypass_reg <= 1'b0;
            end
        end
        else if (shift_dr)
        begin
            if (sel_idcode)
            begin
                idcode_shift <= {tdi, idcode_shift[$bits(idcode_shift)-1:1]};
            end
            else if (sel_dmi)
            begin
                dmi_shift <= {tdi, dmi_shift[dmi_pkg::DMI_WIDTH-1:1]};
            end
            else
            begin
                bypass_reg <= tdi;
            end
        end
    end

    // dmi hold register, read back by the next capture
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dmi_value  <= '0;
            dmi_update <= 1'b0;
        end
        else
        begin
            dmi_update <= update_dr && sel_dmi;
            if (update_dr && sel_dmi)
            begin
                dmi_value <= dmi_shift;
            end
        end
    end

    assign dr_tdo = sel_dmi ? dmi_shift[0] : (sel_idcode ? idcode_shift[0] : bypass_reg);

endmodule

`default_nettype wire

// ==== hdl/ir_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module ir_register (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            capture_ir,
    input  wire            shift_ir,
    input  wire            update_ir,
    input  wire            in_reset,
    input  wire            tdi,
    output jtag_pkg::ir_t  ir,
    output logic           ir_tdo
);

    jtag_pkg::ir_t ir_shift;

    // shift chain, capture loads the instruction currently held
    always_ff @(posedge clk)
    begin
        if (capture_ir)
        begin
            ir_shift <= ir;
        end
        else if (shift_ir)
        begin
            ir_shift <= {tdi, ir_shift[jtag_pkg::IR_WIDTH-1:1]};
        end
    end

    // held instruction
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ir <= jtag_pkg::IR_IDCODE;
        end
        else if (in_reset)
        begin
            // TEST_LOGIC_RESET always selects IDCODE
            ir <= jtag_pkg::IR_IDCODE;
        end
        else if (update_ir)
        begin
            ir <= ir_shift;
        end
    end

    assign ir_tdo = ir_shift[0];

endmodule

`default_nettype wire

// ==== hdl/tap_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module tap_controller (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  tck_rise,
    input  wire  tck_fall,
    input  wire  tms,
    input  wire  ir_tdo,
    input  wire  dr_tdo,
    output logic capture_dr,
    output logic shift_dr,
    output logic update_dr,
    output logic capture_ir,
    output logic shift_ir,
    output logic update_ir,
    output logic in_reset,
    output logic jtag_tdo
);

    jtag_pkg::tap_state_t state;
    jtag_pkg::tap_state_t state_next;

    // standard 1149.1 transitions, tms decides every step
    always_comb
    begin
        case (state)
            jtag_pkg::TEST_LOGIC_RESET:
                state_next = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::RUN_TEST_IDLE:
                state_next = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            jtag_pkg::SELECT_DR_SCAN:
                state_next = tms ? jtag_pkg::SELECT_IR_SCAN : jtag_pkg::CAPTURE_DR;
            jtag_pkg::CAPTURE_DR:
                state_next = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::SHIFT_DR:
                state_next = tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::EXIT1_DR:
                state_next = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::PAUSE_DR:
                state_next = tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::EXIT2_DR:
                state_next = tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::UPDATE_DR:
                state_next = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            // tms high here is the last step of the five-edge reset
            jtag_pkg::SELECT_IR_SCAN:
                state_next = tms ? jtag_pkg::TEST_LOGIC_RESET : jtag_pkg::CAPTURE_IR;
            jtag_pkg::CAPTURE_IR:
                state_next = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::SHIFT_IR:
                state_next = tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::EXIT1_IR:
                state_next = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::PAUSE_IR:
                state_next = tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::EXIT2_IR:
                state_next = tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::UPDATE_IR:
                state_next = tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::RUN_TEST_IDLE;
            default:
                state_next = jtag_pkg::TEST_LOGIC_RESET;
        endcase
    end

    // advance only on a rising jtag_clk edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= jtag_pkg::TEST_LOGIC_RESET;
        end
        else if (tck_rise)
        begin
            state <= state_next;
        end
    end

    // strobes fire on the rising edge that leaves the named state
    assign capture_dr = tck_rise && (state == jtag_pkg::CAPTURE_DR);
    assign shift_dr   = tck_rise && (state == jtag_pkg::SHIFT_DR);
    assign update_dr  = tck_rise && (state == jtag_pkg::UPDATE_DR);
    assign capture_ir = tck_rise && (state == jtag_pkg::CAPTURE_IR);
    assign shift_ir   = tck_rise && (state == jtag_pkg::SHIFT_IR);
    assign update_ir  = tck_rise && (state == jtag_pkg::UPDATE_IR);
    assign in_reset   = (state == jtag_pkg::TEST_LOGIC_RESET);

    // tdo launched on the falling edge, held outside the shift states
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            jtag_tdo <= 1'b0;
        end
        else if (tck_fall)
        begin
            if (state == jtag_pkg::SHIFT_IR)
            begin
                jtag_tdo <= ir_tdo;
            end
            else if (state == jtag_pkg::SHIFT_DR)
            begin
                jtag_tdo <= dr_tdo;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/tck_edge_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module tck_edge_detect #(
    // at least 2 stages
    parameter int SYNC_STAGES = 2
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  jtag_clk,
    input  wire  jtag_tms,
    input  wire  jtag_tdi,
    output logic tck_rise,
    output logic tck_fall,
    output logic tms,
    output logic tdi
);

    // pins enter at bit 0, synchronized value at the MSB
    logic [SYNC_STAGES-1:0] tck_sync;
    logic [SYNC_STAGES-1:0] tms_sync;
    logic [SYNC_STAGES-1:0] tdi_sync;
    logic                   tck_prev;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tck_sync <= '0;
            tms_sync <= '0;
            tdi_sync <= '0;
            tck_prev <= 1'b0;
        end
        else
        begin
            tck_sync <= {tck_sync[SYNC_STAGES-2:0], jtag_clk};
            tms_sync <= {tms_sync[SYNC_STAGES-2:0], jtag_tms};
            tdi_sync <= {tdi_sync[SYNC_STAGES-2:0], jtag_tdi};
            tck_prev <= tck_sync[SYNC_STAGES-1];
        end
    end

    // same depth on all three, so tms/tdi line up with the pulses
    assign tck_rise = tck_sync[SYNC_STAGES-1] & ~tck_prev;
    assign tck_fall = ~tck_sync[SYNC_STAGES-1] & tck_prev;
    assign tms      = tms_sync[SYNC_STAGES-1];
    assign tdi      = tdi_sync[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== hdl/dmi_pkg.sv ====
`default_nettype none

package dmi_pkg;

    localparam int DMI_ABITS     = 10;
    localparam int DMI_DATA_BITS = 32;
    localparam int DMI_OP_BITS   = 2;
    localparam int DMI_WIDTH     = DMI_ABITS + DMI_DATA_BITS + DMI_OP_BITS;

    typedef logic [DMI_ABITS-1:0]     dmi_addr_t;
    typedef logic [DMI_DATA_BITS-1:0] dmi_data_t;
    typedef logic [DMI_OP_BITS-1:0]   dmi_op_t;
    typedef logic [DMI_WIDTH-1:0]     dmi_t;

    // field offsets, op sits at the LSB end and is shifted in first
    localparam int DMI_OP_LSB   = 0;
    localparam int DMI_DATA_LSB = DMI_OP_LSB + DMI_OP_BITS;
    localparam int DMI_ADDR_LSB = DMI_DATA_LSB + DMI_DATA_BITS;

    localparam dmi_op_t DMI_OP_NOP      = 2'd0;
    localparam dmi_op_t DMI_OP_READ     = 2'd1;
    localparam dmi_op_t DMI_OP_WRITE    = 2'd2;
    localparam dmi_op_t DMI_OP_RESERVED = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/jtag_pkg.sv ====
`default_nettype none

package jtag_pkg;

    // IEEE 1149.1 controller states, encoded 0..15
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET,
        RUN_TEST_IDLE,
        SELECT_DR_SCAN,
        CAPTURE_DR,
        SHIFT_DR,
        EXIT1_DR,
        PAUSE_DR,
        EXIT2_DR,
        UPDATE_DR,
        SELECT_IR_SCAN,
        CAPTURE_IR,
        SHIFT_IR,
        EXIT1_IR,
        PAUSE_IR,
        EXIT2_IR,
        UPDATE_IR
    } tap_state_t;

    // riscv debug spec asks for at least 5 IR bits
    localparam int IR_WIDTH = 5;
    typedef logic [IR_WIDTH-1:0] ir_t;

    localparam ir_t IR_IDCODE = 5'h01;
    localparam ir_t IR_DMI    = 5'h11;
    localparam ir_t IR_BYPASS = 5'h1f;

    typedef logic [31:0] idcode_t;

endpackage

`default_nettype wire
